//--- source/lsu_params.svh
// Fixed LSU sizes for a 32-bit core; the queue and counter logic assume at most 2 outstanding
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

////////////////////////////////////////
// Data path
////////////////////////////////////////

// Data and address width
`define LSU_DATA_W 32

// One enable per byte lane
`define LSU_BE_W 4

////////////////////////////////////////
// Bus transfer tracking
////////////////////////////////////////

// Transfers in flight before the request is held off
`define LSU_MAX_OUTST 2

// Counter must hold 0 up to LSU_MAX_OUTST
`define LSU_CNT_W 2

`endif

//--- source/lsu_pkg.sv
// LSU types for 32-bit data; the size encoding is byte 0, half 1, word 2 and 3 is unused
`include "lsu_params.svh"

package lsu_pkg;

  // Access size as coded by the EX stage
  typedef enum logic [1:0] {
    LSU_SIZE_BYTE = 2'b00,
    LSU_SIZE_HALF = 2'b01,
    LSU_SIZE_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////
  // EX stage to LSU
  ////////////////////////////////////////

  // Address is operand_a + operand_b
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] operand_a;
    logic [`LSU_DATA_W-1:0] operand_b;
    logic [`LSU_DATA_W-1:0] wdata;
    logic                   we;
    lsu_size_e              size;
    logic                   sext;
  } lsu_ex_req_t;

  // Address phase of one bus transfer
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] addr;
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;
  } lsu_bus_req_t;

  // Per-transfer info needed when the response comes back
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    logic [1:0] offset;
    logic       last;  // low only on the first half of a split
  } lsu_meta_t;

endpackage

//--- source/lsu_request.sv
// Combinational request path; EX must hold ex_req_i stable while ex_valid_i is high
`include "lsu_params.svh"

module lsu_request import lsu_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         ex_valid_i,
  input  lsu_ex_req_t  ex_req_i,
  input  logic         part_done_i,
  output logic         split_o,
  output lsu_bus_req_t bus_req_data_o,
  output lsu_meta_t    meta_o
);

  logic [`LSU_DATA_W-1:0]   addr;
  logic [1:0]               offset;
  logic                     split_q;
  logic [2*`LSU_BE_W-1:0]   be_mask;
  logic [2*`LSU_BE_W-1:0]   be_wide;
  logic [2*`LSU_DATA_W-1:0] wdata_wide;

  // Effective address
  assign addr   = ex_req_i.operand_a + ex_req_i.operand_b;
  assign offset = addr[1:0];

  ////////////////////////////////////////
  // Split detection
  ////////////////////////////////////////

  // Only the first part of an access can request a split
  always_comb begin
    split_o = 1'b0;
    if (ex_valid_i && !split_q) begin
      case (ex_req_i.size)
        LSU_SIZE_WORD: split_o = (offset != 2'b00);
        LSU_SIZE_HALF: split_o = (offset == 2'b11);
        default:       split_o = 1'b0;
      endcase
    end
  end

  // High while the second part is on the bus
  // Cleared when EX drops the access so the next one starts clean
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!ex_valid_i) begin
      split_q <= 1'b0;
    end else if (part_done_i) begin
      split_q <= split_o;
    end
  end

  ////////////////////////////////////////
  // Byte enables and write data
  ////////////////////////////////////////

  // Mask of the access size at lane 0
  always_comb begin
    case (ex_req_i.size)
      LSU_SIZE_BYTE: be_mask = 8'b0000_0001;
      LSU_SIZE_HALF: be_mask = 8'b0000_0011;
      default:       be_mask = 8'b0000_1111;
    endcase
  end

  // Lower nibble is the first word, upper nibble spills into the next one
  assign be_wide = be_mask << offset;

  // Rotate write data left by the byte offset
  assign wdata_wide = {ex_req_i.wdata, ex_req_i.wdata} << {offset, 3'b000};

  // Second part goes to the next aligned word with the spilled lanes
  always_comb begin
    bus_req_data_o.we    = ex_req_i.we;
    bus_req_data_o.wdata = wdata_wide[2*`LSU_DATA_W-1:`LSU_DATA_W];
    if (split_q) begin
      bus_req_data_o.addr = {addr[`LSU_DATA_W-1:2], 2'b00} + `LSU_DATA_W'd4;
      bus_req_data_o.be   = be_wide[2*`LSU_BE_W-1:`LSU_BE_W];
    end else begin
      bus_req_data_o.addr = addr;
      bus_req_data_o.be   = be_wide[`LSU_BE_W-1:0];
    end
  end

  // Response-side record; the offset always refers to the original address
  always_comb begin
    meta_o.size   = ex_req_i.size;
    meta_o.sext   = ex_req_i.sext;
    meta_o.we     = ex_req_i.we;
    meta_o.offset = offset;
    meta_o.last   = !split_o;
  end

endmodule

//--- source/lsu_ctrl.sv
// Handshake control; assumes bus responses arrive at least one cycle after grant, in order
`include "lsu_params.svh"

module lsu_ctrl import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ex_valid_i,
  input  logic      split_i,
  input  lsu_meta_t meta_i,
  input  logic      bus_gnt_i,
  input  logic      bus_rvalid_i,
  output logic      bus_req_o,
  output logic      part_done_o,
  output logic      ex_ready_o,
  output lsu_meta_t meta_head_o,
  output logic      busy_o
);

  localparam int PTR_W = $clog2(`LSU_MAX_OUTST);
  localparam logic [`LSU_CNT_W-1:0] MAX_CNT = `LSU_CNT_W'(`LSU_MAX_OUTST);

  logic [`LSU_CNT_W-1:0] cnt_q;
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  grant;
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  lsu_meta_t             meta_q [`LSU_MAX_OUTST];

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  // Request straight from EX valid, held off when the bus is full
  assign bus_req_o   = ex_valid_i && (cnt_q < MAX_CNT);
  assign grant       = bus_req_o && bus_gnt_i;
  assign part_done_o = grant;

  // EX completes on the grant of its last part
  assign ex_ready_o = grant && !split_i;

  assign busy_o = ex_valid_i || (cnt_q != '0);

  ////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////

  always_comb begin
    case ({grant, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////////////////////////
  // Meta queue, grant order
  ////////////////////////////////////////

  // Occupancy equals cnt_q, so no full or empty flags here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (grant) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (bus_rvalid_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      meta_q[wr_ptr_q] <= meta_i;
    end
  end

  // Head matches the response currently on the bus
  assign meta_head_o = meta_q[rd_ptr_q];

  // A response always belongs to an earlier grant
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> (cnt_q != '0));

  // Request and its record from lsu_request stay put until granted
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req_o && !bus_gnt_i) |=> (bus_req_o && $stable(meta_i) && $stable(split_i)));

endmodule

//--- source/lsu_response.sv
// Response path; meta_i must be the record of the transfer that bus_rvalid_i answers
`include "lsu_params.svh"

module lsu_response import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   bus_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] bus_rdata_i,
  input  logic                   bus_err_i,
  input  lsu_meta_t              meta_i,
  output logic                   wb_valid_o,
  output logic [`LSU_DATA_W-1:0] wb_rdata_o,
  output logic                   wb_err_o
);

  logic [`LSU_DATA_W-1:0]   rdata_q;
  logic                     err_q;
  logic                     is_split;
  logic [2*`LSU_DATA_W-1:0] rdata_full;
  logic [2*`LSU_DATA_W-1:0] rdata_aligned;
  logic [`LSU_DATA_W-1:0]   rdata_ext;

  ////////////////////////////////////////
  // First-half holding register
  ////////////////////////////////////////

  // Lower word of a split access
  always_ff @(posedge clk) begin
    if (bus_rvalid_i && !meta_i.last) begin
      rdata_q <= bus_rdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (bus_rvalid_i && !meta_i.last) begin
      err_q <= bus_err_i;
    end
  end

  // Same rule as the request side split detection
  assign is_split = ((meta_i.size == LSU_SIZE_WORD) && (meta_i.offset != 2'b00)) ||
                    ((meta_i.size == LSU_SIZE_HALF) && (meta_i.offset == 2'b11));

  ////////////////////////////////////////
  // Realign and extend
  ////////////////////////////////////////

  // Unsplit data is doubled so the shift wraps the upper bytes down
  assign rdata_full    = is_split ? {bus_rdata_i, rdata_q} : {bus_rdata_i, bus_rdata_i};
  assign rdata_aligned = rdata_full >> {meta_i.offset, 3'b000};

  always_comb begin
    case (meta_i.size)
      LSU_SIZE_BYTE: rdata_ext = {{24{meta_i.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      LSU_SIZE_HALF: rdata_ext = {{16{meta_i.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      default:       rdata_ext = rdata_aligned[`LSU_DATA_W-1:0];
    endcase
  end

  // One strobe per access, on its last part
  assign wb_valid_o = bus_rvalid_i && meta_i.last;

  // Stores return zero data
  assign wb_rdata_o = meta_i.we ? '0 : rdata_ext;

  // Error from either half
  assign wb_err_o = bus_err_i || (is_split && err_q);

endmodule

//--- source/lsu_top.sv
// LSU top; no result back-pressure, so wb_valid_o must be taken in the cycle it is high
`include "lsu_params.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  // EX side
  input  logic                   ex_valid_i,
  input  lsu_ex_req_t            ex_req_i,
  output logic                   ex_ready_o,
  // Bus side
  output logic                   bus_req_o,
  output lsu_bus_req_t           bus_req_data_o,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] bus_rdata_i,
  input  logic                   bus_err_i,
  // Result side
  output logic                   wb_valid_o,
  output logic [`LSU_DATA_W-1:0] wb_rdata_o,
  output logic                   wb_err_o,
  output logic                   busy_o
);

  logic      split;
  logic      part_done;
  lsu_meta_t meta_req;
  lsu_meta_t meta_head;

  // Address, enables and record for the current part
  lsu_request request_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid_i),
    .ex_req_i       (ex_req_i),
    .part_done_i    (part_done),
    .split_o        (split),
    .bus_req_data_o (bus_req_data_o),
    .meta_o         (meta_req)
  );

  // Handshakes, counter and meta queue
  lsu_ctrl ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid_i),
    .split_i      (split),
    .meta_i       (meta_req),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_req_o    (bus_req_o),
    .part_done_o  (part_done),
    .ex_ready_o   (ex_ready_o),
    .meta_head_o  (meta_head),
    .busy_o       (busy_o)
  );

  // Load data assembly and result strobe
  lsu_response response_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .bus_err_i    (bus_err_i),
    .meta_i       (meta_head),
    .wb_valid_o   (wb_valid_o),
    .wb_rdata_o   (wb_rdata_o),
    .wb_err_o     (wb_err_o)
  );

endmodule

//--- sim/lsu_mem_model.sv
// Bus memory model of 256 bytes indexed by addr[7:0]; one response per cycle, in grant order
`include "lsu_params.svh"

module lsu_mem_model import lsu_pkg::*; #(
  parameter logic [7:0]  ERR_BASE = 8'hc0,
  parameter int          ERR_LEN  = 8,
  parameter logic [31:0] SEED     = 32'hd70b
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   bus_req_i,
  input  lsu_bus_req_t           bus_req_data_i,
  output logic                   bus_gnt_o,
  output logic                   bus_rvalid_o,
  output logic [`LSU_DATA_W-1:0] bus_rdata_o,
  output logic                   bus_err_o,
  output int                     max_outst_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0]             mem [256];
  logic [`LSU_DATA_W-1:0] rdata_q [$];
  logic                   err_q [$];
  int                     due_q [$];
  integer                 seed;
  int                     cycle;
  int                     outst;
  logic [7:0]             word;
  logic                   hit;

  // Fill pattern over the whole byte address
  initial begin
    seed = SEED;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i * 29 + 71);
    end
    {bus_gnt_o, bus_rvalid_o, bus_err_o, bus_rdata_o} = '0;
    {cycle, outst, max_outst_o} = '0;
  end

  always @(posedge clk) begin
    cycle++;
    if (!rst_n) begin
      rdata_q.delete();
      err_q.delete();
      due_q.delete();
      outst = 0;
    end else begin
      // Response taken at this edge
      if (bus_rvalid_o) begin
        void'(rdata_q.pop_front());
        void'(err_q.pop_front());
        void'(due_q.pop_front());
        outst--;
      end
      // Address phase accepted at this edge
      if (bus_req_i && bus_gnt_o) begin
        word = {bus_req_data_i.addr[7:2], 2'b00};
        hit  = (word >= ERR_BASE) && (word < ERR_BASE + ERR_LEN);
        for (int i = 0; i < 4; i++) begin
          if (bus_req_data_i.we && bus_req_data_i.be[i] && !hit) begin
            mem[8'(word + i)] = bus_req_data_i.wdata[8*i +: 8];
          end
        end
        rdata_q.push_back({mem[8'(word + 3)], mem[8'(word + 2)], mem[8'(word + 1)], mem[word]});
        err_q.push_back(hit);
        due_q.push_back(cycle + 1 + ($random(seed) & 3));
        outst++;
        if (outst > max_outst_o) max_outst_o = outst;
      end
    end
    // Outputs change just after the edge
    #1;
    bus_gnt_o    = rst_n && (($random(seed) & 3) != 0);
    bus_rvalid_o = (due_q.size() != 0) && (due_q[0] <= cycle);
    bus_rdata_o  = bus_rvalid_o ? rdata_q[0] : '0;
    bus_err_o    = bus_rvalid_o ? err_q[0] : 1'b0;
  end

endmodule

//--- sim/lsu_tb.sv
// LSU testbench; addresses stay below 8'hf8 so that no access wraps the 256-byte model
`include "lsu_params.svh"

module lsu_tb import lsu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NUM_OPS    = 300;
  localparam int          NUM_RAND   = 200;
  localparam logic [31:0] SEED       = 32'hd70b;
  localparam logic [7:0]  ERR_BASE   = 8'hc0;
  localparam int          ERR_LEN    = 8;
  localparam int          MAX_DELAY  = 4;
  localparam int          TIMEOUT_NS = NUM_OPS * 2 * 12 * 4;

  logic clk, rst_n, ex_valid, ex_ready, bus_req, bus_gnt, bus_rvalid, bus_err;
  logic wb_valid, wb_err, busy;
  logic [31:0] bus_rdata, wb_rdata;
  lsu_ex_req_t ex_req;
  lsu_bus_req_t bus_req_data;
  int max_outst, errors, checks, tests;
  integer seed;
  string test_name;
  logic [7:0] shadow [256];
  logic [32:0] exp_q [$];

  lsu_top dut_i (
    .clk(clk), .rst_n(rst_n), .ex_valid_i(ex_valid), .ex_req_i(ex_req), .ex_ready_o(ex_ready),
    .bus_req_o(bus_req), .bus_req_data_o(bus_req_data), .bus_gnt_i(bus_gnt),
    .bus_rvalid_i(bus_rvalid), .bus_rdata_i(bus_rdata), .bus_err_i(bus_err),
    .wb_valid_o(wb_valid), .wb_rdata_o(wb_rdata), .wb_err_o(wb_err), .busy_o(busy)
  );

  lsu_mem_model #(.ERR_BASE(ERR_BASE), .ERR_LEN(ERR_LEN), .SEED(SEED)) mem_i (
    .clk(clk), .rst_n(rst_n), .bus_req_i(bus_req), .bus_req_data_i(bus_req_data),
    .bus_gnt_o(bus_gnt), .bus_rvalid_o(bus_rvalid), .bus_rdata_o(bus_rdata),
    .bus_err_o(bus_err), .max_outst_o(max_outst)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic in_window(input logic [7:0] a);
    return (a >= ERR_BASE) && (a < ERR_BASE + ERR_LEN);
  endfunction

  // Expected {err, data} from little-endian bytes at addr upward, then extended
  function automatic logic [32:0] ref_result(input logic [7:0] addr, input logic [1:0] size,
                                             input logic sext, input logic we);
    logic [31:0] data;
    logic err;
    data = '0;
    err  = 1'b0;
    for (int i = 0; i < (1 << size); i++) begin
      data[8*i +: 8] = shadow[8'(addr + i)];
      err = err | in_window(8'(addr + i));
    end
    if (size == 2'd0 && sext) data[31:8] = {24{data[7]}};
    if (size == 2'd1 && sext) data[31:16] = {16{data[15]}};
    return {err, we ? 32'h0 : data};
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // Drive one access until ex_ready and check the address phase of each part
  task automatic do_access(input logic we, input logic [1:0] size, input logic sext,
                           input logic [7:0] addr, input logic [31:0] wdata);
    logic [7:0] wide;
    logic [31:0] opa;
    int n_gnt;
    // Lane of each accessed byte over this word and the next
    wide = '0;
    for (int k = 0; k < (1 << size); k++) begin
      wide[addr[1:0] + k] = 1'b1;
    end
    opa   = $random(seed);
    n_gnt = 0;
    exp_q.push_back(ref_result(addr, size, sext, we));
    for (int i = 0; we && i < (1 << size); i++) begin
      if (!in_window(8'(addr + i))) shadow[8'(addr + i)] = wdata[8*i +: 8];
    end
    #1;
    ex_valid = 1'b1;
    ex_req   = '{operand_a: opa, operand_b: {24'h0, addr} - opa, wdata: wdata, we: we,
                 size: lsu_size_e'(size), sext: sext};
    forever begin
      @(posedge clk);
      if (!busy) check("busy", 1, busy);
      if (bus_req && bus_gnt) begin
        check("grant addr", (n_gnt == 0) ? {24'h0, addr} : {24'h0, addr[7:2], 2'b00} + 4,
              bus_req_data.addr);
        check("grant be", (n_gnt == 0) ? wide[3:0] : wide[7:4], bus_req_data.be);
        n_gnt++;
      end
      if (ex_ready) break;
    end
    check("grant count", (wide[7:4] != 0) ? 2 : 1, n_gnt);
  endtask

  // Drop valid and wait for every outstanding result
  task automatic finish_test();
    #1 ex_valid = 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    tests++;
    $display("test %s done, %0d errors so far", test_name, errors);
  endtask

  // Comparing process
  always @(posedge clk) begin
    logic [32:0] exp;
    if (rst_n && wb_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Result strobe with no access outstanding in test %s", test_name);
      end else begin
        exp = exp_q.pop_front();
        check("err", exp[32], wb_err);
        if (!exp[32]) check("rdata", exp[31:0], wb_rdata);
      end
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS * 1ns);
    $display("Timeout after %0d ns, test %s did not finish", TIMEOUT_NS, test_name);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    seed = SEED;
    {ex_valid, ex_req, rst_n, errors, checks, tests} = '0;
    for (int i = 0; i < 256; i++) shadow[i] = 8'(i * 29 + 71);
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    test_name = "aligned_words";
    for (int i = 0; i < 8; i++) do_access(1, 2, 0, 8'(4 * i), $random(seed));
    for (int i = 0; i < 8; i++) do_access(0, 2, 0, 8'(4 * i), '0);
    finish_test();
    test_name = "byte_half";
    do_access(1, 2, 0, 8'h20, 32'h8f7e_f180);
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 2; s++) begin
        do_access(0, 0, 1'(s), 8'(8'h20 + off), '0);
        if (off < 3) do_access(0, 1, 1'(s), 8'(8'h20 + off), '0);
      end
    end
    finish_test();
    test_name = "split";
    do_access(1, 2, 0, 8'h31, 32'h1122_3344);
    do_access(1, 2, 0, 8'h36, 32'hc5d6_e7f8);
    do_access(1, 1, 0, 8'h53, 32'h0000_9abc);
    do_access(0, 2, 0, 8'h31, '0);
    do_access(0, 2, 0, 8'h36, '0);
    do_access(0, 1, 1, 8'h53, '0);
    do_access(0, 2, 0, 8'h62, '0);
    do_access(0, 1, 0, 8'h73, '0);
    finish_test();
    test_name = "random_mix";
    for (int i = 0; i < NUM_RAND; i++) begin
      do_access(1'($random(seed)), 2'(($random(seed) & 32'h7fff) % 3), 1'($random(seed)),
                8'($random(seed) & 8'h7f) + 8'(($random(seed) & 1) * 8'h70), $random(seed));
    end
    finish_test();
    if (max_outst > `LSU_MAX_OUTST) check("max outstanding", `LSU_MAX_OUTST, max_outst);
    test_name = "bus_error";
    do_access(0, 2, 0, 8'hc0, '0);
    do_access(0, 2, 0, 8'hbe, '0);
    do_access(0, 2, 0, 8'hc6, '0);
    do_access(0, 2, 0, 8'h40, '0);
    do_access(0, 0, 1, 8'hc8, '0);
    finish_test();
    test_name = "idle";
    repeat (MAX_DELAY) @(posedge clk);
    check("busy", 0, busy);
    repeat (20) begin
      @(posedge clk);
      if (bus_req) check("bus_req", 0, bus_req);
    end
    finish_test();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+source
source/lsu_pkg.sv
source/lsu_request.sv
source/lsu_ctrl.sv
source/lsu_response.sv
source/lsu_top.sv
sim/lsu_mem_model.sv
sim/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide from the simulation log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module lsu_tb \
  -Mdir obj_dir -o lsu_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log
! grep -qF '*** FAILED ***' sim.log && grep -qF '*** PASSED ***' sim.log \
  && echo "simulation ok" || { echo "simulation reported failure"; exit 1; }
